/* sources.f */
logic/exec_pkg.sv
logic/int_alu_unit.sv
logic/mult_unit.sv
logic/load_store_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster_top.sv
testbench/exec_cluster_tb.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  # shared types first
  - logic/exec_pkg.sv
  # execution units and arbiter
  - logic/int_alu_unit.sv
  - logic/mult_unit.sv
  - logic/load_store_unit.sv
  - logic/cdb_arbiter.sv
  # top level
  - logic/exec_cluster_top.sv
  - target: test
    files:
      - testbench/exec_cluster_tb.sv

/* testbench/exec_cluster_tb.sv */
// execution cluster testbench
`timescale 1ns/10ps
module exec_cluster_tb;
	import exec_pkg::*;

	localparam int          CLK_PERIOD  = 100;
	localparam int          MULT_STAGES = 3;
	localparam int          MEM_WORDS   = 32;
	localparam logic [31:0] DATA_BASE   = 32'h1001_0000;
	localparam int          N_INT       = 40;
	localparam int          N_MULT      = 16;
	localparam int          N_STORE     = 12;
	localparam int          N_MIX       = 20;
	// loads repeat every store address and add one unwritten word
	localparam int N_TOTAL         = N_INT + N_MULT + 2 * N_STORE + 1 + 3 * N_MIX;
	localparam int WATCHDOG_CYCLES = 10 + N_TOTAL * (MULT_STAGES + 4) + 200;
	localparam int DRAIN_CYCLES    = 50;

	logic        clk;
	logic        arst_n;
	int_issue_t  int_issue;
	logic        int_issue_valid;
	logic        int_issue_ready;
	mult_issue_t mult_issue;
	logic        mult_issue_valid;
	logic        mult_issue_ready;
	mem_issue_t  mem_issue;
	logic        mem_issue_valid;
	logic        mem_issue_ready;
	cdb_t        cdb;

	logic [31:0] lfsr_state = 32'h54a0;
	tag_t        tag_count  = '0;
	logic [31:0] shadow_mem [MEM_WORDS];
	int_issue_t  int_stim [$];
	mult_issue_t mult_stim [$];
	mem_issue_t  mem_stim [$];
	cdb_t        int_q [$];
	cdb_t        mult_q [$];
	cdb_t        mem_q [$];
	logic [3:0]  store_idx [$];

	exec_cluster_top #(
		.MULT_STAGES(MULT_STAGES),
		.MEM_WORDS(MEM_WORDS),
		.DATA_BASE(DATA_BASE)
	) dut (
		.clk, .arst_n,
		.int_issue, .int_issue_valid, .int_issue_ready,
		.mult_issue, .mult_issue_valid, .mult_issue_ready,
		.mem_issue, .mem_issue_valid, .mem_issue_ready,
		.cdb
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val        = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic tag_t next_tag();
		tag_count = tag_count + 1'b1;
		return tag_count;
	endfunction

	function automatic logic [2:0] pick_logic_f3();
		case (lfsr_bits(2))
			0: return F3_XOR;
			1: return F3_OR;
			default: return F3_AND;
		endcase
	endfunction

	function automatic int_issue_t make_int();
		int_issue_t i;
		logic [2:0] kind;
		i          = '0;
		i.rs1_data = lfsr_bits(32);
		i.rs2_data = lfsr_bits(32);
		kind       = 3'(lfsr_bits(3));
		case (kind)
			3'd0: i.opcode = OPC_R_TYPE;
			3'd1: begin
				i.opcode = OPC_R_TYPE;
				i.func7  = F7_SUB;
			end
			3'd2: begin
				i.opcode = OPC_R_TYPE;
				i.func3  = pick_logic_f3();
			end
			3'd3: begin
				i.opcode = OPC_I_TYPE;
				i.func3  = lfsr_bits(1) ? pick_logic_f3() : F3_ADD_SUB;
			end
			3'd4: i.opcode = OPC_LUI;
			default: begin
				// equal operands half the time so both branch outcomes occur
				i.opcode = OPC_BRANCH;
				i.func3  = kind[0] ? F3_BNE : F3_BEQ;
				if (lfsr_bits(1)) begin
					i.rs2_data = i.rs1_data;
				end
			end
		endcase
		return i;
	endfunction

	function automatic mult_issue_t make_mult();
		mult_issue_t m;
		m.rs1_data = lfsr_bits(32);
		m.rs2_data = lfsr_bits(32);
		m.rd_tag   = '0;
		return m;
	endfunction

	// base plus offset lands on word idx of the data segment
	function automatic mem_issue_t make_mem(input mem_op_t op, input logic [4:0] idx);
		mem_issue_t m;
		m.op       = op;
		m.imm      = lfsr_bits(3) << 2;
		m.rs1_data = DATA_BASE + 32'(idx) * 4 - m.imm;
		m.rs2_data = lfsr_bits(32);
		m.rd_tag   = '0;
		return m;
	endfunction

	function automatic cdb_t expect_int(input int_issue_t i);
		cdb_t e;
		e = '0;
		if (i.opcode == OPC_BRANCH) begin
			e.branch       = 1'b1;
			e.branch_taken = (i.func3 == F3_BEQ) ? (i.rs1_data == i.rs2_data) :
				(i.rs1_data != i.rs2_data);
			return e;
		end
		e.valid = 1'b1;
		e.tag   = i.rd_tag;
		if (i.opcode == OPC_LUI) begin
			e.data = i.rs2_data;
		end else if (i.func3 == F3_XOR) begin
			e.data = i.rs1_data ^ i.rs2_data;
		end else if (i.func3 == F3_OR) begin
			e.data = i.rs1_data | i.rs2_data;
		end else if (i.func3 == F3_AND) begin
			e.data = i.rs1_data & i.rs2_data;
		end else if (i.opcode == OPC_R_TYPE && i.func7 == F7_SUB) begin
			e.data = i.rs1_data - i.rs2_data;
		end else begin
			e.data = i.rs1_data + i.rs2_data;
		end
		return e;
	endfunction

	function automatic cdb_t expect_mult(input mult_issue_t m);
		cdb_t        e;
		logic [63:0] full;
		full    = 64'(m.rs1_data) * 64'(m.rs2_data);
		e       = '0;
		e.valid = 1'b1;
		e.tag   = m.rd_tag;
		e.data  = full[31:0];
		return e;
	endfunction

	// stores update the shadow copy, loads queue what they should read
	task automatic model_mem(input mem_issue_t m);
		int   idx;
		cdb_t e;
		idx = (m.rs1_data + m.imm - DATA_BASE) >> 2;
		if (m.op == MEM_STORE) begin
			shadow_mem[idx] = m.rs2_data;
		end else begin
			e       = '0;
			e.valid = 1'b1;
			e.tag   = m.rd_tag;
			e.data  = shadow_mem[idx];
			mem_q.push_back(e);
		end
	endtask

	// handshake sampled mid-cycle, inputs changed just after the edge
	task automatic drive_all(input logic gaps);
		logic int_go;
		logic mult_go;
		logic mem_go;
		while (int_stim.size() > 0 || mult_stim.size() > 0 || mem_stim.size() > 0 ||
				int_issue_valid || mult_issue_valid || mem_issue_valid) begin
			@(negedge clk);
			int_go  = int_issue_valid && int_issue_ready;
			mult_go = mult_issue_valid && mult_issue_ready;
			mem_go  = mem_issue_valid && mem_issue_ready;
			@(posedge clk);
			#1;
			if (int_go) begin
				int_q.push_back(expect_int(int_issue));
				int_issue_valid = 1'b0;
			end
			if (mult_go) begin
				mult_q.push_back(expect_mult(mult_issue));
				mult_issue_valid = 1'b0;
			end
			if (mem_go) begin
				model_mem(mem_issue);
				mem_issue_valid = 1'b0;
			end
			if (!int_issue_valid && int_stim.size() > 0 && (!gaps || lfsr_bits(1))) begin
				int_issue        = int_stim.pop_front();
				int_issue.rd_tag = next_tag();
				int_issue_valid  = 1'b1;
			end
			if (!mult_issue_valid && mult_stim.size() > 0 && (!gaps || lfsr_bits(1))) begin
				mult_issue        = mult_stim.pop_front();
				mult_issue.rd_tag = next_tag();
				mult_issue_valid  = 1'b1;
			end
			if (!mem_issue_valid && mem_stim.size() > 0 && (!gaps || lfsr_bits(1))) begin
				mem_issue        = mem_stim.pop_front();
				mem_issue.rd_tag = next_tag();
				mem_issue_valid  = 1'b1;
			end
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		a_field_match: assert (got === exp)
			else abort_run($sformatf("[FAIL] %0d ns %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// each unit publishes in order, so a tag must match a queue head
	task automatic check_publication(input cdb_t got);
		cdb_t exp;
		if (got.branch) begin
			a_branch_owed: assert (int_q.size() > 0 && int_q[0].branch)
				else abort_run("branch published while no branch was outstanding");
			exp = int_q.pop_front();
		end else if (mult_q.size() > 0 && mult_q[0].tag == got.tag) begin
			exp = mult_q.pop_front();
		end else if (mem_q.size() > 0 && mem_q[0].tag == got.tag) begin
			exp = mem_q.pop_front();
		end else begin
			a_result_owed: assert (int_q.size() > 0 && !int_q[0].branch && int_q[0].tag == got.tag)
				else abort_run($sformatf("result with tag %0d matches no outstanding instruction",
					got.tag));
			exp = int_q.pop_front();
		end
		check_field("cdb.valid", got.valid, exp.valid);
		check_field("cdb.tag", got.tag, exp.tag);
		check_field("cdb.data", got.data, exp.data);
		check_field("cdb.branch_taken", got.branch_taken, exp.branch_taken);
	endtask

	function automatic int results_owed();
		return int_q.size() + mult_q.size() + mem_q.size();
	endfunction

	always @(negedge clk) begin
		if (arst_n && (cdb.valid || cdb.branch)) begin
			check_publication(cdb);
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !arst_n |->
		int_issue_ready && mult_issue_ready && mem_issue_ready && !cdb.valid && !cdb.branch)
		else abort_run("issue ready low or cdb active during reset");

	a_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |->
		int_issue_ready && mult_issue_ready && mem_issue_ready)
		else abort_run("issue ready low right after reset");

	a_one_kind: assert property (@(posedge clk) disable iff (!arst_n)
		!(cdb.valid && cdb.branch))
		else abort_run("cdb carries a register result and a branch in the same cycle");

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired with results still missing from the cdb");
	end

	initial begin
		arst_n           = 1'b1;
		int_issue        = '0;
		int_issue_valid  = 1'b0;
		mult_issue       = '0;
		mult_issue_valid = 1'b0;
		mem_issue        = '0;
		mem_issue_valid  = 1'b0;
		for (int k = 0; k < MEM_WORDS; k++) begin
			shadow_mem[k] = '0;
		end
		#1;
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// integer, lui and branches with random gaps
		for (int k = 0; k < N_INT; k++) begin
			int_stim.push_back(make_int());
		end
		drive_all(1'b1);

		// back-to-back multiplies fill the pipe
		for (int k = 0; k < N_MULT; k++) begin
			mult_stim.push_back(make_mult());
		end
		drive_all(1'b0);

		// stores to the lower half, then loads of the same words
		for (int k = 0; k < N_STORE; k++) begin
			store_idx.push_back(4'(lfsr_bits(4)));
			mem_stim.push_back(make_mem(MEM_STORE, {1'b0, store_idx[k]}));
		end
		foreach (store_idx[k]) begin
			mem_stim.push_back(make_mem(MEM_LOAD, {1'b0, store_idx[k]}));
		end
		mem_stim.push_back(make_mem(MEM_LOAD, {1'b1, 4'(lfsr_bits(4))}));
		drive_all(1'b1);

		// all three units busy at once
		for (int k = 0; k < N_MIX; k++) begin
			int_stim.push_back(make_int());
			mult_stim.push_back(make_mult());
			mem_stim.push_back(make_mem((k % 2 == 0) ? MEM_STORE : MEM_LOAD,
				{1'b0, 4'(lfsr_bits(4))}));
		end
		drive_all(1'b0);

		for (int c = 0; c < DRAIN_CYCLES && results_owed() > 0; c++) begin
			@(posedge clk);
		end
		if (results_owed() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run($sformatf("%0d results never reached the cdb", results_owed()));
		end
	end

endmodule

/* logic/exec_cluster_top.sv */
// execution cluster top level
`timescale 1ns/10ps
module exec_cluster_top #(
	parameter int                        MULT_STAGES = 3,
	parameter int                        MEM_WORDS   = 32,
	parameter logic [exec_pkg::XLEN-1:0] DATA_BASE   = 32'h1001_0000
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  exec_pkg::int_issue_t  int_issue,
	input  logic                  int_issue_valid,
	output logic                  int_issue_ready,
	input  exec_pkg::mult_issue_t mult_issue,
	input  logic                  mult_issue_valid,
	output logic                  mult_issue_ready,
	input  exec_pkg::mem_issue_t  mem_issue,
	input  logic                  mem_issue_valid,
	output logic                  mem_issue_ready,
	output exec_pkg::cdb_t        cdb
);
	import exec_pkg::*;

	cdb_t int_result;
	cdb_t mult_result;
	cdb_t mem_result;
	logic int_pending;
	logic mult_pending;
	logic mem_pending;
	logic int_grant;
	logic mult_grant;
	logic mem_grant;

	int_alu_unit u_int (
		.clk, .arst_n,
		.issue(int_issue), .issue_valid(int_issue_valid), .issue_ready(int_issue_ready),
		.result(int_result), .pending(int_pending), .grant(int_grant)
	);

	mult_unit #(.MULT_STAGES(MULT_STAGES)) u_mult (
		.clk, .arst_n,
		.issue(mult_issue), .issue_valid(mult_issue_valid), .issue_ready(mult_issue_ready),
		.result(mult_result), .pending(mult_pending), .grant(mult_grant)
	);

	load_store_unit #(.MEM_WORDS(MEM_WORDS), .DATA_BASE(DATA_BASE)) u_lsu (
		.clk, .arst_n,
		.issue(mem_issue), .issue_valid(mem_issue_valid), .issue_ready(mem_issue_ready),
		.result(mem_result), .pending(mem_pending), .grant(mem_grant)
	);

	cdb_arbiter u_arb (
		.clk, .arst_n,
		.mult_result, .mem_result, .int_result,
		.mult_pending, .mem_pending, .int_pending,
		.mult_grant, .mem_grant, .int_grant,
		.cdb
	);

endmodule

/* logic/cdb_arbiter.sv */
// fixed-priority CDB arbiter
`timescale 1ns/10ps
module cdb_arbiter (
	input  logic           clk,
	input  logic           arst_n,
	input  exec_pkg::cdb_t mult_result,
	input  exec_pkg::cdb_t mem_result,
	input  exec_pkg::cdb_t int_result,
	input  logic           mult_pending,
	input  logic           mem_pending,
	input  logic           int_pending,
	output logic           mult_grant,
	output logic           mem_grant,
	output logic           int_grant,
	output exec_pkg::cdb_t cdb
);

	// mult first, then load/store, then int
	assign mult_grant = mult_pending;
	assign mem_grant  = mem_pending && !mult_pending;
	assign int_grant  = int_pending && !mult_pending && !mem_pending;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cdb <= '0;
		end else if (mult_grant) begin
			cdb <= mult_result;
		end else if (mem_grant) begin
			cdb <= mem_result;
		end else if (int_grant) begin
			cdb <= int_result;
		end else begin
			// idle cycle, payload left as is
			cdb.valid  <= 1'b0;
			cdb.branch <= 1'b0;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({mult_grant, mem_grant, int_grant}));

	// every grant turns into a publication on the next cycle
	a_grant_publishes: assert property (@(posedge clk) disable iff (!arst_n)
		mult_grant || mem_grant || int_grant |=> cdb.valid || cdb.branch);

endmodule

/* logic/load_store_unit.sv */
// load/store unit with word data memory
`timescale 1ns/10ps
module load_store_unit #(
	parameter int                        MEM_WORDS = 32,
	parameter logic [exec_pkg::XLEN-1:0] DATA_BASE = 32'h1001_0000
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  exec_pkg::mem_issue_t issue,
	input  logic                 issue_valid,
	output logic                 issue_ready,
	output exec_pkg::cdb_t       result,
	output logic                 pending,
	input  logic                 grant
);
	import exec_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [XLEN-1:0]  mem [MEM_WORDS];
	logic [XLEN-1:0]  eff_addr;
	logic [IDX_W-1:0] word_idx;
	logic             accept;
	logic             is_load;

	// byte offset from the data segment base
	assign eff_addr = issue.rs1_data + issue.imm - DATA_BASE;
	assign word_idx = eff_addr[IDX_W+1:2];
	assign is_load  = (issue.op == MEM_LOAD);

	// stalls behind a waiting load so stores stay in order
	assign issue_ready = !pending || grant;
	assign accept      = issue_valid && issue_ready;

	// unwritten words read back as zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (accept && !is_load) begin
			mem[word_idx] <= issue.rs2_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
		end else if (accept && is_load) begin
			pending <= 1'b1;
		end else if (grant) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_load) begin
			result.valid        <= 1'b1;
			result.tag          <= issue.rd_tag;
			result.data         <= mem[word_idx];
			result.branch       <= 1'b0;
			result.branch_taken <= 1'b0;
		end
	end

	a_addr_ok: assert property (@(posedge clk) disable iff (!arst_n)
		accept |-> eff_addr[1:0] == 2'b00 && eff_addr < XLEN'(MEM_WORDS * 4));

endmodule

/* logic/mult_unit.sv */
// pipelined multiplier
`timescale 1ns/10ps
module mult_unit #(
	parameter int MULT_STAGES = 3
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  exec_pkg::mult_issue_t issue,
	input  logic                  issue_valid,
	output logic                  issue_ready,
	output exec_pkg::cdb_t        result,
	output logic                  pending,
	input  logic                  grant
);
	import exec_pkg::*;

	localparam int LAST = MULT_STAGES - 1;

	// tag and product travelling down the pipe
	typedef struct packed {
		tag_t            tag;
		logic [XLEN-1:0] prod;
	} mult_stage_t;

	logic [MULT_STAGES-1:0] stg_valid;
	mult_stage_t            stg [MULT_STAGES];
	logic                   advance;
	logic                   accept;

	// whole pipe stalls while the last stage waits for its grant
	assign advance     = !stg_valid[LAST] || grant;
	assign issue_ready = advance;
	assign accept      = issue_valid && advance;
	assign pending     = stg_valid[LAST];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stg_valid <= '0;
		end else if (advance) begin
			stg_valid[0] <= accept;
			for (int i = 1; i < MULT_STAGES; i++) begin
				stg_valid[i] <= stg_valid[i-1];
			end
		end
	end

	// low XLEN bits of the product only
	always_ff @(posedge clk) begin
		if (advance) begin
			stg[0].tag  <= issue.rd_tag;
			stg[0].prod <= issue.rs1_data * issue.rs2_data;
			for (int i = 1; i < MULT_STAGES; i++) begin
				stg[i] <= stg[i-1];
			end
		end
	end

	assign result.valid        = 1'b1;
	assign result.tag          = stg[LAST].tag;
	assign result.data         = stg[LAST].prod;
	assign result.branch       = 1'b0;
	assign result.branch_taken = 1'b0;

	a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
		pending && !grant |=> pending && $stable(result));

endmodule

/* logic/int_alu_unit.sv */
// integer ALU and branch unit
`timescale 1ns/10ps
module int_alu_unit (
	input  logic                 clk,
	input  logic                 arst_n,
	input  exec_pkg::int_issue_t issue,
	input  logic                 issue_valid,
	output logic                 issue_ready,
	output exec_pkg::cdb_t       result,
	output logic                 pending,
	input  logic                 grant
);
	import exec_pkg::*;

	logic            accept;
	logic            is_branch;
	logic            taken;
	logic [XLEN-1:0] alu_data;
	cdb_t            next_result;

	// result register frees on the granting edge
	assign issue_ready = !pending || grant;
	assign accept      = issue_valid && issue_ready;

	always_comb begin
		alu_data  = '0;
		is_branch = 1'b0;
		taken     = 1'b0;
		case (issue.opcode)
			OPC_R_TYPE: begin
				case (issue.func3)
					F3_ADD_SUB: alu_data = (issue.func7 == F7_SUB) ?
						issue.rs1_data - issue.rs2_data : issue.rs1_data + issue.rs2_data;
					F3_XOR:  alu_data = issue.rs1_data ^ issue.rs2_data;
					F3_OR:   alu_data = issue.rs1_data | issue.rs2_data;
					F3_AND:  alu_data = issue.rs1_data & issue.rs2_data;
					default: alu_data = '0;
				endcase
			end
			OPC_I_TYPE: begin
				case (issue.func3)
					F3_ADD_SUB: alu_data = issue.rs1_data + issue.rs2_data;
					F3_XOR:     alu_data = issue.rs1_data ^ issue.rs2_data;
					F3_OR:      alu_data = issue.rs1_data | issue.rs2_data;
					F3_AND:     alu_data = issue.rs1_data & issue.rs2_data;
					default:    alu_data = '0;
				endcase
			end
			OPC_LUI: alu_data = issue.rs2_data;
			OPC_BRANCH: begin
				is_branch = 1'b1;
				case (issue.func3)
					F3_BEQ:  taken = (issue.rs1_data == issue.rs2_data);
					F3_BNE:  taken = (issue.rs1_data != issue.rs2_data);
					default: taken = 1'b0;
				endcase
			end
			default: alu_data = '0;
		endcase
	end

	// branches publish with no register result
	assign next_result.valid        = !is_branch;
	assign next_result.tag          = is_branch ? '0 : issue.rd_tag;
	assign next_result.data         = alu_data;
	assign next_result.branch       = is_branch;
	assign next_result.branch_taken = taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (grant) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result <= next_result;
		end
	end

	// a waiting result is never overwritten by a new issue
	a_hold_until_grant: assert property (@(posedge clk) disable iff (!arst_n)
		pending && !grant |=> pending && $stable(result));

endmodule

/* logic/exec_pkg.sv */
// execution back end shared types
package exec_pkg;

	// datapath and tag widths
	localparam int XLEN  = 32;
	localparam int TAG_W = 6;

	typedef logic [TAG_W-1:0] tag_t;

	// major opcodes handled by the integer unit
	typedef enum logic [6:0] {
		OPC_R_TYPE = 7'h33,
		OPC_I_TYPE = 7'h13,
		OPC_LUI    = 7'h37,
		OPC_BRANCH = 7'h63
	} rv_opcode_t;

	// func3 codes for ALU operations
	localparam logic [2:0] F3_ADD_SUB = 3'h0;
	localparam logic [2:0] F3_XOR     = 3'h4;
	localparam logic [2:0] F3_OR      = 3'h6;
	localparam logic [2:0] F3_AND     = 3'h7;

	// func3 codes for branches
	localparam logic [2:0] F3_BEQ = 3'h0;
	localparam logic [2:0] F3_BNE = 3'h1;

	// func7 selecting SUB over ADD
	localparam logic [6:0] F7_SUB = 7'h20;

	typedef enum logic {
		MEM_LOAD  = 1'b0,
		MEM_STORE = 1'b1
	} mem_op_t;

	// integer issue, rs2_data carries the immediate for I-type and LUI
	typedef struct packed {
		rv_opcode_t      opcode;
		logic [2:0]      func3;
		logic [6:0]      func7;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		tag_t            rd_tag;
	} int_issue_t;

	typedef struct packed {
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		tag_t            rd_tag;
	} mult_issue_t;

	// rs2_data is the store data
	typedef struct packed {
		mem_op_t         op;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic [XLEN-1:0] imm;
		tag_t            rd_tag;
	} mem_issue_t;

	// one common data bus publication
	typedef struct packed {
		logic            valid;
		tag_t            tag;
		logic [XLEN-1:0] data;
		logic            branch;
		logic            branch_taken;
	} cdb_t;

endpackage
